// ==== all.f ====
noc_pkg.sv
node_config.sv
route_compute.sv
input_port.sv
output_arbiter.sv
mesh_router.sv
mesh_router_checker.sv
tb_mesh_router.sv

// ==== Bender.yml ====
package:
  name: mesh_router

sources:
  - noc_pkg.sv
  - node_config.sv
  - route_compute.sv
  - input_port.sv
  - output_arbiter.sv
  - mesh_router.sv
  - target: test
    files:
      - mesh_router_checker.sv
      - tb_mesh_router.sv

// ==== tb_mesh_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mesh_router;
   import noc_pkg::*;

   logic                             clk = 1'b0;
   logic                             rst_n;
   logic                             cfg_req;
   logic [2*coord_w-1:0]             cfg_addr;
   logic                             cfg_ack;
   logic [num_ports-1:0]             in_req;
   logic [num_ports-1:0][flit_w-1:0] in_flit;
   logic [num_ports-1:0]             in_ack;
   logic [num_ports-1:0]             out_req;
   logic [num_ports-1:0][flit_w-1:0] out_flit;
   logic [num_ports-1:0]             out_ack;

   int seed = 32'heecf_bf8c;
   // 40 cycles for each of the 338 flits, plus slack
   int cycle_limit = 40 * 338 + 200;
   int cycles = 0;
   int errors = 0;
   int err_mark = 0;
   int tests = 0;
   int failed = 0;
   // assertion failures already folded into errors
   int assert_seen = 0;

   // model address and expected {port, flit} entries
   logic [coord_w-1:0] model_x;
   logic [coord_w-1:0] model_y;
   logic [10:0]        exp_q[$];
   int                 last_port;
   logic [7:0]         last_flit;

   // outputs held off by the back-pressure test
   logic [num_ports-1:0] hold;

   // round-robin bookkeeping on the east output
   logic contend = 1'b0;
   int   stream_n = 8;
   int   served[num_ports];
   int   waited[num_ports];

   always #2 clk = ~clk;

   mesh_router u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .cfg_req  (cfg_req),
      .cfg_addr (cfg_addr),
      .cfg_ack  (cfg_ack),
      .in_req   (in_req),
      .in_flit  (in_flit),
      .in_ack   (in_ack),
      .out_req  (out_req),
      .out_flit (out_flit),
      .out_ack  (out_ack)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("run stopped after %0d cycles, traffic never drained", cycles);
         $display("Errors found");
         $finish;
      end
   end

   ////////////////////
   // model and checks
   ////////////////////

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (got !== exp) begin
         $display("Error %s expected %h got %h", name, exp, got);
         errors++;
      end
   endtask

   // xy rule, x first, then y growing southward
   function automatic port_e xy_port(input logic [7:0] f);
      logic [coord_w-1:0] dx;
      logic [coord_w-1:0] dy;
      dx = f[dest_x_lsb +: coord_w];
      dy = f[dest_y_lsb +: coord_w];
      if (dx > model_x) return port_east;
      if (dx < model_x) return port_west;
      if (dy > model_y) return port_south;
      if (dy < model_y) return port_north;
      return port_local;
   endfunction

   // mode 0 random, 1 eastbound tagged with source, 2 never east
   function automatic logic [7:0] make_flit(input int p, input int mode);
      logic [7:0] r;
      r = 8'($random(seed));
      if (mode == 1) return {4'(p), 2'b11, r[1:0]};
      if (mode == 2) return {r[7:4], 2'(int'(r[3:2]) % (int'(model_x) + 1)), r[1:0]};
      return r;
   endfunction

   task automatic note_delivery(input int p, input logic [7:0] f);
      int hit;
      int src;
      hit = -1;
      foreach (exp_q[i]) begin
         if (hit < 0 && exp_q[i] == {3'(p), f}) hit = i;
      end
      if (hit < 0) begin
         $display("unexpected flit %h on output %0d", f, p);
         errors++;
      end else begin
         exp_q.delete(hit);
      end
      last_port = p;
      last_flit = f;
      if (contend && p == port_east) begin
         src = f[7:4];
         served[src]++;
         waited[src] = 0;
         // a live contender sits out at most four grants
         for (int s = 0; s < num_ports; s++) begin
            if (s != src && s != port_east && served[s] < stream_n) begin
               waited[s]++;
               if (waited[s] > 4) begin
                  $display("input %0d passed over %0d times on east", s, waited[s]);
                  errors++;
               end
            end
         end
      end
   endtask

   ////////////////////
   // link drivers
   ////////////////////

   task automatic send_flit(input int p, input logic [7:0] f);
      exp_q.push_back({xy_port(f), f});
      @(posedge clk);
      in_flit[p] <= f;
      in_req[p]  <= 1'b1;
      do @(negedge clk); while (!in_ack[p]);
      @(posedge clk);
      in_req[p] <= 1'b0;
      do @(negedge clk); while (in_ack[p]);
   endtask

   task automatic send_stream(input int p, input int n, input int mode);
      repeat (n) send_flit(p, make_flit(p, mode));
   endtask

   // parallel streams on the inputs picked by mask
   task automatic run_streams(input int n, input int mode, input logic [4:0] mask);
      fork
         if (mask[0]) send_stream(0, n, mode);
         if (mask[1]) send_stream(1, n, mode);
         if (mask[2]) send_stream(2, n, mode);
         if (mask[3]) send_stream(3, n, mode);
         if (mask[4]) send_stream(4, n, mode);
      join
   endtask

   // slow ack, 0 to 3 cycles each way
   task automatic respond(input int p);
      int dly;
      wait (rst_n === 1'b1);
      forever begin
         do @(negedge clk); while (!(out_req[p] && !hold[p]));
         dly = $unsigned($random(seed)) % 4;
         repeat (dly) @(posedge clk);
         @(posedge clk);
         out_ack[p] <= 1'b1;
         note_delivery(p, out_flit[p]);
         do @(negedge clk); while (out_req[p]);
         dly = $unsigned($random(seed)) % 4;
         repeat (dly) @(posedge clk);
         @(posedge clk);
         out_ack[p] <= 1'b0;
      end
   endtask

   for (genvar g = 0; g < num_ports; g++) begin : g_resp
      initial respond(g);
   end

   task automatic write_addr(input logic [1:0] x, input logic [1:0] y);
      @(posedge clk);
      cfg_addr <= {x, y};
      cfg_req  <= 1'b1;
      do @(negedge clk); while (!cfg_ack);
      @(posedge clk);
      cfg_req <= 1'b0;
      do @(negedge clk); while (cfg_ack);
      model_x = x;
      model_y = y;
   endtask

   // leftovers are lost flits
   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 400) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d flits were never delivered", exp_q.size());
         errors += exp_q.size();
         exp_q.delete();
      end
      repeat (10) @(posedge clk);
   endtask

   task automatic end_test(input string name);
      int new_fails;
      // handshake assertions that fired during this test
      new_fails = u_dut.u_checker.fails - assert_seen;
      if (new_fails > 0) begin
         $display("%0d handshake assertions failed", new_fails);
         errors += new_fails;
         assert_seen += new_fails;
      end
      tests++;
      if (errors == err_mark) begin
         $display("test %s: passed", name);
      end else begin
         failed++;
         $display("test %s: failed, %0d mismatches", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   ////////////////////
   // test sequence
   ////////////////////

   initial begin
      int rises;
      logic prev;
      logic [7:0] f;
      rst_n    = 1'b0;
      cfg_req  = 1'b0;
      cfg_addr = '0;
      in_req   = '0;
      in_flit  = '0;
      out_ack  = '0;
      hold     = '0;
      model_x  = '0;
      model_y  = '0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check("in_ack", 0, in_ack);
      check("out_req", 0, out_req);
      check("cfg_ack", 0, cfg_ack);
      end_test("reset");

      // every destination from the local input
      write_addr(2'd1, 2'd2);
      for (int d = 0; d < 16; d++) begin
         f = {4'($random(seed)), 4'(d)};
         send_flit(port_local, f);
         wait_drain();
         check("out port", xy_port(f), last_port);
         check("out_flit", f, last_flit);
      end
      end_test("config and routing");

      run_streams(40, 0, 5'b11111);
      wait_drain();
      end_test("random traffic");

      // four inputs fight for east
      foreach (served[s]) begin
         served[s] = 0;
         waited[s] = 0;
      end
      contend = 1'b1;
      run_streams(stream_n, 1, 5'b11101);
      wait_drain();
      contend = 1'b0;
      for (int s = 0; s < num_ports; s++) begin
         if (s != port_east) check($sformatf("served[%0d]", s), stream_n, served[s]);
      end
      end_test("contention");

      // east stalled, local is its only user
      hold[port_east] = 1'b1;
      fork
         send_stream(port_local, 10, 1);
         run_streams(10, 2, 5'b11110);
         begin
            rises = 0;
            prev  = 1'b0;
            repeat (50) begin
               @(negedge clk);
               if (in_ack[port_local] && !prev) rises++;
               prev = in_ack[port_local];
            end
            // one flit in the arbiter, one in the buffer
            check("in_ack[0] rises", 2, rises);
            check("in_ack[0]", 0, in_ack[port_local]);
            hold[port_east] = 1'b0;
         end
      join
      wait_drain();
      end_test("back-pressure");

      write_addr(2'd3, 2'd0);
      run_streams(8, 0, 5'b11111);
      wait_drain();
      end_test("reconfiguration");

      $display("tests %0d, failed %0d, mismatches %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== mesh_router_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mesh_router_checker (
   input logic                                               clk,
   input logic                                               rst_n,
   input logic                                               cfg_req,
   input logic                                               cfg_ack,
   input logic [noc_pkg::num_ports-1:0]                      in_req,
   input logic [noc_pkg::num_ports-1:0]                      in_ack,
   input logic [noc_pkg::num_ports-1:0]                      out_req,
   input logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] out_flit,
   input logic [noc_pkg::num_ports-1:0]                      out_ack
);
   import noc_pkg::*;

   // running count of assertion failures
   int fails = 0;

   for (genvar p = 0; p < num_ports; p++) begin : g_port
      // sender keeps req up until the far side acks
      a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
         out_req[p] && !out_ack[p] |=> out_req[p])
         else begin
            $error("out_req[%0d] dropped before out_ack", p);
            fails++;
         end

      // data frozen for the whole req phase
      a_flit_stable: assert property (@(posedge clk) disable iff (!rst_n)
         out_req[p] && $past(out_req[p]) |-> $stable(out_flit[p]))
         else begin
            $error("out_flit[%0d] changed under out_req", p);
            fails++;
         end

      // receiver acks only a live request
      a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
         $rose(in_ack[p]) |-> $past(in_req[p]))
         else begin
            $error("in_ack[%0d] rose without in_req", p);
            fails++;
         end
   end

   // config slave releases only after the master let go
   a_cfg_release: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(cfg_ack) |-> $past(!cfg_req))
      else begin
         $error("cfg_ack fell while cfg_req was high");
         fails++;
      end

endmodule

bind mesh_router mesh_router_checker u_checker (
   .clk      (clk),
   .rst_n    (rst_n),
   .cfg_req  (cfg_req),
   .cfg_ack  (cfg_ack),
   .in_req   (in_req),
   .in_ack   (in_ack),
   .out_req  (out_req),
   .out_flit (out_flit),
   .out_ack  (out_ack)
);

`default_nettype wire

// ==== mesh_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module mesh_router (
   input  logic                                               clk,
   input  logic                                               rst_n,
   input  logic                                               cfg_req,
   input  logic [2*noc_pkg::coord_w-1:0]                       cfg_addr,
   output logic                                               cfg_ack,
   input  logic [noc_pkg::num_ports-1:0]                      in_req,
   input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] in_flit,
   output logic [noc_pkg::num_ports-1:0]                      in_ack,
   output logic [noc_pkg::num_ports-1:0]                      out_req,
   output logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] out_flit,
   input  logic [noc_pkg::num_ports-1:0]                      out_ack
);
   import noc_pkg::*;

   // node address to every route compute
   logic [coord_w-1:0] node_x;
   logic [coord_w-1:0] node_y;

   // route_req indexed [input][output]
   logic [num_ports-1:0][num_ports-1:0] route_req;
   // req_vec indexed [output][input]
   logic [num_ports-1:0][num_ports-1:0] req_vec;
   // grant indexed [output][input]
   logic [num_ports-1:0][num_ports-1:0] grant;
   // grant_t indexed [input][output]
   logic [num_ports-1:0][num_ports-1:0] grant_t;

   logic [num_ports-1:0]              pop;
   logic [num_ports-1:0][flit_w-1:0]  held_flit;

   node_config u_cfg (
      .clk      (clk),
      .rst_n    (rst_n),
      .cfg_req  (cfg_req),
      .cfg_addr (cfg_addr),
      .cfg_ack  (cfg_ack),
      .node_x   (node_x),
      .node_y   (node_y)
   );

   ////////////////////
   // crossbar wiring
   ////////////////////

   // transpose both matrices
   for (genvar i = 0; i < num_ports; i++) begin : g_xpose_i
      for (genvar o = 0; o < num_ports; o++) begin : g_xpose_o
         assign req_vec[o][i] = route_req[i][o];
         assign grant_t[i][o] = grant[o][i];
      end
      // any arbiter taking this input frees it
      assign pop[i] = |grant_t[i];
   end

   for (genvar i = 0; i < num_ports; i++) begin : g_in
      input_port u_in (
         .clk       (clk),
         .rst_n     (rst_n),
         .in_req    (in_req[i]),
         .in_flit   (in_flit[i]),
         .in_ack    (in_ack[i]),
         .node_x    (node_x),
         .node_y    (node_y),
         .route_req (route_req[i]),
         .held_flit (held_flit[i]),
         .pop       (pop[i])
      );
   end

   // every arbiter sees every held flit
   for (genvar o = 0; o < num_ports; o++) begin : g_out
      output_arbiter u_arb (
         .clk      (clk),
         .rst_n    (rst_n),
         .req_vec  (req_vec[o]),
         .flit_vec (held_flit),
         .grant    (grant[o]),
         .out_req  (out_req[o]),
         .out_flit (out_flit[o]),
         .out_ack  (out_ack[o])
      );
   end

endmodule

`default_nettype wire

// ==== output_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_arbiter (
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic [noc_pkg::num_ports-1:0]                  req_vec,
   input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] flit_vec,
   output logic [noc_pkg::num_ports-1:0]                  grant,
   output logic                                           out_req,
   output logic [noc_pkg::flit_w-1:0]                     out_flit,
   input  logic                                           out_ack
);
   import noc_pkg::*;

   // sender handshake state
   link_state_e tx_state;

   // last input served
   port_e last_win;

   // this cycle's pick
   port_e win_idx;

   // some input is asking
   logic hit;

   // arbitration happens only while the link is idle
   logic grant_now;

   ////////////////////
   // round robin
   ////////////////////

   // scan starts one past the last winner, wraps at num_ports
   always_comb begin
      int idx;
      hit     = 1'b0;
      win_idx = last_win;
      for (int k = 1; k <= num_ports; k++) begin
         idx = int'(last_win) + k;
         if (idx >= num_ports) idx = idx - num_ports;
         if (!hit && req_vec[idx]) begin
            hit     = 1'b1;
            win_idx = port_e'(idx);
         end
      end
   end

   assign grant_now = (tx_state == link_idle) && hit;

   // single-cycle one-hot grant, doubles as the input's pop
   always_comb begin
      grant = '0;
      if (grant_now) grant[win_idx] = 1'b1;
   end

   ////////////////////
   // four-phase sender
   ////////////////////

   assign out_req = (tx_state == link_wait_ack);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_state <= link_idle;
         // first search begins at local
         last_win <= port_north;
      end else begin
         case (tx_state)
            link_idle: begin
               if (grant_now) begin
                  tx_state <= link_wait_ack;
                  last_win <= win_idx;
               end
            end
            // hold req for as long as the far side needs
            link_wait_ack: begin
               if (out_ack) tx_state <= link_wait_release;
            end
            // no new grant until ack is back low
            link_wait_release: begin
               if (!out_ack) tx_state <= link_idle;
            end
            default: tx_state <= link_idle;
         endcase
      end
   end

   // own copy so the input buffer frees at grant
   always_ff @(posedge clk) begin
      if (grant_now) out_flit <= flit_vec[win_idx];
   end

endmodule

`default_nettype wire

// ==== input_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_port (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         in_req,
   input  logic [noc_pkg::flit_w-1:0]   in_flit,
   output logic                         in_ack,
   input  logic [noc_pkg::coord_w-1:0]  node_x,
   input  logic [noc_pkg::coord_w-1:0]  node_y,
   output logic [noc_pkg::num_ports-1:0] route_req,
   output logic [noc_pkg::flit_w-1:0]   held_flit,
   input  logic                         pop
);
   import noc_pkg::*;

   // receiver handshake state
   link_state_e rx_state;

   // one-flit buffer occupied
   logic full;

   // accept this cycle
   logic take;

   // route of the held flit
   logic [num_ports-1:0] port_sel;

   ////////////////////
   // four-phase receiver
   ////////////////////

   // only from idle, and only into an empty buffer
   assign take = (rx_state == link_idle) && in_req && !full;

   // ack is high for the whole wait_release phase
   assign in_ack = (rx_state == link_wait_release);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_state <= link_idle;
      end else begin
         case (rx_state)
            link_idle: begin
               if (take) rx_state <= link_wait_release;
            end
            link_wait_release: begin
               // sender let go
               if (!in_req) rx_state <= link_idle;
            end
            default: rx_state <= link_idle;
         endcase
      end
   end

   ////////////////////
   // flit buffer
   ////////////////////

   // capture on accept
   always_ff @(posedge clk) begin
      if (take) held_flit <= in_flit;
   end

   // set on accept, cleared on the grant cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (take) begin
         full <= 1'b1;
      end else if (pop) begin
         full <= 1'b0;
      end
   end

   // destination fields straight off the buffer
   route_compute u_route (
      .dest_x   (held_flit[dest_x_lsb +: coord_w]),
      .dest_y   (held_flit[dest_y_lsb +: coord_w]),
      .node_x   (node_x),
      .node_y   (node_y),
      .port_sel (port_sel)
   );

   // request only while something is held
   assign route_req = full ? port_sel : '0;

endmodule

`default_nettype wire

// ==== route_compute.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_compute (
   input  logic [noc_pkg::coord_w-1:0]   dest_x,
   input  logic [noc_pkg::coord_w-1:0]   dest_y,
   input  logic [noc_pkg::coord_w-1:0]   node_x,
   input  logic [noc_pkg::coord_w-1:0]   node_y,
   output logic [noc_pkg::num_ports-1:0] port_sel
);
   import noc_pkg::*;

   // chosen direction
   port_e dir;

   ////////////////////
   // xy decision
   ////////////////////

   // x first, then y
   // unsigned compare on 2-bit coords
   always_comb begin
      if (dest_x > node_x) begin
         dir = port_east;
      end else if (dest_x < node_x) begin
         dir = port_west;
      end else if (dest_y > node_y) begin
         // y grows southward
         dir = port_south;
      end else if (dest_y < node_y) begin
         dir = port_north;
      end else begin
         // arrived
         dir = port_local;
      end
   end

   ////////////////////
   // one-hot encode
   ////////////////////

   // exactly one bit, indexed by port enum
   always_comb begin
      port_sel      = '0;
      port_sel[dir] = 1'b1;
   end

endmodule

`default_nettype wire

// ==== node_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module node_config (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         cfg_req,
   input  logic [2*noc_pkg::coord_w-1:0] cfg_addr,
   output logic                         cfg_ack,
   output logic [noc_pkg::coord_w-1:0]  node_x,
   output logic [noc_pkg::coord_w-1:0]  node_y
);
   import noc_pkg::*;

   // new write seen, slave not yet acked
   logic wr_take;

   // release seen, ack still up
   logic wr_done;

   assign wr_take = cfg_req && !cfg_ack;
   assign wr_done = !cfg_req && cfg_ack;

   ////////////////////
   // address register
   ////////////////////

   // cfg_addr packs x high, y low, same as a flit destination
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // node 0,0 out of reset
         node_x <= '0;
         node_y <= '0;
      end else if (wr_take) begin
         node_x <= cfg_addr[coord_w +: coord_w];
         node_y <= cfg_addr[0 +: coord_w];
      end
   end

   ////////////////////
   // four-phase slave
   ////////////////////

   // ack rises on the write edge
   // drops one edge after req is seen low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg_ack <= 1'b0;
      end else if (wr_take) begin
         cfg_ack <= 1'b1;
      end else if (wr_done) begin
         cfg_ack <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== noc_pkg.sv ====
`default_nettype none

package noc_pkg;

   ////////////////////
   // mesh geometry
   ////////////////////

   // one coordinate of the 4x4 mesh
   localparam int coord_w = 2;

   // local plus four neighbors
   localparam int num_ports = 5;

   // single-flit packets
   localparam int flit_w = 8;

   ////////////////////
   // flit layout
   ////////////////////

   // dest x in bits 3:2
   localparam int dest_x_lsb = 2;

   // dest y in bits 1:0
   localparam int dest_y_lsb = 0;

   // upper nibble is payload, carried untouched

   ////////////////////
   // enums
   ////////////////////

   // port index, also the bit position in a one-hot select
   typedef enum logic [2:0] {
      port_local = 3'd0,
      port_east  = 3'd1,
      port_west  = 3'd2,
      port_south = 3'd3,
      port_north = 3'd4
   } port_e;

   // four-phase link states
   // the receiver only walks idle and wait_release
   typedef enum logic [1:0] {
      link_idle         = 2'd0,
      link_wait_ack     = 2'd1,
      link_wait_release = 2'd2
   } link_state_e;

endpackage

`default_nettype wire
